/* hdl/rv_settings.svh */
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

// data path and instruction width
`define RV_XLEN 32

// byte address width of the PC
// word index on iaddr/daddr drops the two low bits
`define RV_ADDR_W 10

// architectural registers, x0 included
`define RV_REG_COUNT 32

// fetch starts here after reset
`define RV_RESET_PC 0

`endif

/* hdl/rv_pkg.sv */
`default_nettype none
`include "rv_settings.svh"

package rv_pkg;

    // basic widths
    typedef logic [`RV_XLEN-1:0] word_t;
    typedef logic [`RV_ADDR_W-1:0] pc_t;
    // word index into either memory
    typedef logic [`RV_ADDR_W-3:0] waddr_t;
    typedef logic [$clog2(`RV_REG_COUNT)-1:0] reg_idx_t;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111
    } opcode_e;

    // ALU_ADD must stay at zero, an all-zero ctrl is a no-op
    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_SLL    = 4'd2,
        ALU_SLT    = 4'd3,
        ALU_SLTU   = 4'd4,
        ALU_XOR    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SRA    = 4'd7,
        ALU_OR     = 4'd8,
        ALU_AND    = 4'd9,
        ALU_COPY_B = 4'd10
    } alu_op_e;

    // writeback source
    typedef enum logic [1:0] {
        WB_ALU = 2'd0,
        WB_MEM = 2'd1,
        WB_PC4 = 2'd2
    } wb_sel_e;

    typedef struct packed {
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    branch;
        logic    jump;
        logic    alu_src_imm;
        logic    a_is_pc;
        // funct3 bit 0 of a branch
        logic    bne;
        alu_op_e alu_op;
        wb_sel_e wb_sel;
    } ctrl_t;

    // fetch to decode
    typedef struct packed {
        logic  valid;
        pc_t   pc;
        word_t instr;
    } if_id_t;

    // decode to execute
    typedef struct packed {
        logic     valid;
        ctrl_t    ctrl;
        pc_t      pc;
        word_t    rs1_val;
        word_t    rs2_val;
        word_t    imm;
        reg_idx_t rd;
    } id_ex_t;

    // execute to memory
    typedef struct packed {
        logic     valid;
        ctrl_t    ctrl;
        pc_t      pc;
        word_t    rs2_val;
        reg_idx_t rd;
        word_t    alu_result;
        logic     equal;
        pc_t      target;
    } ex_mem_t;

    // memory to writeback, reg_write already qualified by valid
    typedef struct packed {
        wb_sel_e  wb_sel;
        logic     reg_write;
        reg_idx_t rd;
        word_t    alu_result;
        word_t    load_data;
        pc_t      pc_plus4;
    } mem_wb_t;

endpackage

`default_nettype wire

/* hdl/rv_decoder.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_decoder import rv_pkg::*; (
    input  wire word_t instr,
    output ctrl_t      ctrl,
    output word_t      imm
);

    opcode_e    opcode;
    logic [2:0] funct3;
    // funct7 bit 5, selects SUB and SRA
    logic       funct7_alt;

    word_t imm_i;
    word_t imm_s;
    word_t imm_b;
    word_t imm_u;
    word_t imm_j;

    assign opcode     = opcode_e'(instr[6:0]);
    assign funct3     = instr[14:12];
    assign funct7_alt = instr[30];

    // immediate formats
    // all sign-extended from bit 31 except U
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    // funct3 to ALU operation, shared by OP and OP_IMM
    function automatic alu_op_e funct_to_alu(input logic [2:0] f3, input logic alt);
        alu_op_e op;
        case (f3)
            3'b000: op = alt ? ALU_SUB : ALU_ADD;
            3'b001: op = ALU_SLL;
            3'b010: op = ALU_SLT;
            3'b011: op = ALU_SLTU;
            3'b100: op = ALU_XOR;
            3'b101: op = alt ? ALU_SRA : ALU_SRL;
            3'b110: op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    always_comb begin
        // unknown opcode falls through as a bubble
        ctrl = ctrl_t'('0);
        imm  = '0;
        case (opcode)
            OPC_OP: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = funct_to_alu(funct3, funct7_alt);
            end
            OPC_OP_IMM: begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                // no SUBI, bit 30 only matters for SRAI
                ctrl.alu_op      = funct_to_alu(funct3, funct7_alt && funct3 == 3'b101);
                imm              = imm_i;
            end
            OPC_LOAD: begin
                ctrl.reg_write   = 1'b1;
                ctrl.mem_read    = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.alu_op      = ALU_ADD;
                ctrl.wb_sel      = WB_MEM;
                imm              = imm_i;
            end
            OPC_STORE: begin
                ctrl.mem_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.alu_op      = ALU_ADD;
                imm              = imm_s;
            end
            OPC_BRANCH: begin
                // rs1 vs rs2 through the ALU equality flag
                ctrl.branch = 1'b1;
                ctrl.bne    = funct3[0];
                ctrl.alu_op = ALU_SUB;
                imm         = imm_b;
            end
            OPC_JAL: begin
                ctrl.reg_write = 1'b1;
                ctrl.jump      = 1'b1;
                ctrl.wb_sel    = WB_PC4;
                imm            = imm_j;
            end
            OPC_LUI: begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.alu_op      = ALU_COPY_B;
                imm              = imm_u;
            end
            OPC_AUIPC: begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.a_is_pc     = 1'b1;
                ctrl.alu_op      = ALU_ADD;
                imm              = imm_u;
            end
            default: begin
                ctrl = ctrl_t'('0);
            end
        endcase
    end

endmodule

`default_nettype wire

/* hdl/rv_regfile.sv */
`timescale 1ns/100ps
`default_nettype none
`include "rv_settings.svh"

module rv_regfile import rv_pkg::*; (
    input  wire logic     CLK,
    input  wire logic     RESET_N,
    input  wire reg_idx_t rs1,
    input  wire reg_idx_t rs2,
    input  wire reg_idx_t rd,
    input  wire word_t    wdata,
    input  wire logic     we,
    output word_t         rdata1,
    output word_t         rdata2
);

    // x0 has no storage
    word_t regs [1:`RV_REG_COUNT-1];

    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            for (int i = 1; i < `RV_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin
            regs[rd] <= wdata;
        end
    end

    // write-first
    // a result in writeback is seen by decode in the same cycle
    assign rdata1 = (rs1 == '0)              ? '0    :
                    (we && rd == rs1)        ? wdata :
                                               regs[rs1];

    assign rdata2 = (rs2 == '0)              ? '0    :
                    (we && rd == rs2)        ? wdata :
                                               regs[rs2];

endmodule

`default_nettype wire

/* hdl/rv_alu.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_alu import rv_pkg::*; (
    input  wire alu_op_e op,
    input  wire word_t   a,
    input  wire word_t   b,
    output word_t        result,
    output logic         equal
);

    // only the low five bits shift
    logic [4:0] shamt;

    assign shamt = b[4:0];

    // BEQ/BNE compare on this
    assign equal = (a == b);

    always_comb begin
        case (op)
            ALU_ADD: begin
                result = a + b;
            end
            ALU_SUB: begin
                result = a - b;
            end
            ALU_SLL: begin
                result = a << shamt;
            end
            ALU_SLT: begin
                // signed compare, result is 0 or 1
                result = word_t'($signed(a) < $signed(b));
            end
            ALU_SLTU: begin
                result = word_t'(a < b);
            end
            ALU_XOR: begin
                result = a ^ b;
            end
            ALU_SRL: begin
                result = a >> shamt;
            end
            ALU_SRA: begin
                // sign bit fills from the left
                result = word_t'($signed(a) >>> shamt);
            end
            ALU_OR: begin
                result = a | b;
            end
            ALU_AND: begin
                result = a & b;
            end
            ALU_COPY_B: begin
                // LUI
                result = b;
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* hdl/rv_core.sv */
`timescale 1ns/100ps
`default_nettype none
`include "rv_settings.svh"

module rv_core import rv_pkg::*; (
    input  wire logic  CLK,
    input  wire logic  RESET_N,
    output waddr_t     iaddr,
    input  wire word_t idata,
    output waddr_t     daddr,
    input  wire word_t ddata_r,
    output word_t      ddata_w,
    output logic       mem_read,
    output logic       mem_write
);

    // fetch
    pc_t pc;
    pc_t pc_plus4;
    pc_t pc_next;

    // stage registers
    if_id_t  if_id;
    id_ex_t  id_ex;
    ex_mem_t ex_mem;
    mem_wb_t mem_wb;

    // decode
    ctrl_t ctrl_id;
    word_t imm_id;
    word_t rs1_val_id;
    word_t rs2_val_id;

    // execute
    word_t alu_a;
    word_t alu_b;
    word_t alu_result;
    logic  alu_equal;
    pc_t   target_ex;

    // memory
    logic take_branch;

    // writeback
    word_t wb_value;

    // fetch stage
    assign pc_plus4 = pc + pc_t'(4);
    // redirect from memory stage wins over sequential fetch
    assign pc_next  = take_branch ? ex_mem.target : pc_plus4;
    assign iaddr    = pc[`RV_ADDR_W-1:2];

    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            pc <= pc_t'(`RV_RESET_PC);
        end else begin
            pc <= pc_next;
        end
    end

    // IF/ID
    // wrong-path fetch is dropped on a taken branch
    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            if_id <= '0;
        end else begin
            if_id.valid <= !take_branch;
            if_id.pc    <= pc;
            if_id.instr <= idata;
        end
    end

    // decode stage
    rv_decoder decoder0 (
        .instr (if_id.instr),
        .ctrl  (ctrl_id),
        .imm   (imm_id)
    );

    // written from MEM/WB, read with rs fields of IF/ID
    rv_regfile regfile0 (
        .CLK     (CLK),
        .RESET_N (RESET_N),
        .rs1     (if_id.instr[19:15]),
        .rs2     (if_id.instr[24:20]),
        .rd      (mem_wb.rd),
        .wdata   (wb_value),
        .we      (mem_wb.reg_write),
        .rdata1  (rs1_val_id),
        .rdata2  (rs2_val_id)
    );

    // ID/EX
    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            id_ex <= '0;
        end else begin
            id_ex.valid   <= if_id.valid && !take_branch;
            id_ex.ctrl    <= ctrl_id;
            id_ex.pc      <= if_id.pc;
            id_ex.rs1_val <= rs1_val_id;
            id_ex.rs2_val <= rs2_val_id;
            id_ex.imm     <= imm_id;
            id_ex.rd      <= if_id.instr[11:7];
        end
    end

    // execute stage
    // AUIPC takes the PC as operand A
    assign alu_a = id_ex.ctrl.a_is_pc ? word_t'(id_ex.pc) : id_ex.rs1_val;
    assign alu_b = id_ex.ctrl.alu_src_imm ? id_ex.imm : id_ex.rs2_val;

    rv_alu alu0 (
        .op     (id_ex.ctrl.alu_op),
        .a      (alu_a),
        .b      (alu_b),
        .result (alu_result),
        .equal  (alu_equal)
    );

    // branch and JAL target, separate from the ALU
    assign target_ex = id_ex.pc + id_ex.imm[`RV_ADDR_W-1:0];

    // EX/MEM
    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            ex_mem <= '0;
        end else begin
            ex_mem.valid      <= id_ex.valid && !take_branch;
            ex_mem.ctrl       <= id_ex.ctrl;
            ex_mem.pc         <= id_ex.pc;
            ex_mem.rs2_val    <= id_ex.rs2_val;
            ex_mem.rd         <= id_ex.rd;
            ex_mem.alu_result <= alu_result;
            ex_mem.equal      <= alu_equal;
            ex_mem.target     <= target_ex;
        end
    end

    // memory stage
    // BEQ taken on equal, BNE on not equal
    assign take_branch = ex_mem.valid &&
                         ((ex_mem.ctrl.branch && (ex_mem.equal != ex_mem.ctrl.bne)) ||
                          ex_mem.ctrl.jump);

    assign daddr     = ex_mem.alu_result[`RV_ADDR_W-1:2];
    assign ddata_w   = ex_mem.rs2_val;
    // bubbles never touch memory
    assign mem_read  = ex_mem.valid && ex_mem.ctrl.mem_read;
    assign mem_write = ex_mem.valid && ex_mem.ctrl.mem_write;

    // MEM/WB
    // load data sampled straight off ddata_r
    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            mem_wb <= '0;
        end else begin
            mem_wb.wb_sel     <= ex_mem.ctrl.wb_sel;
            mem_wb.reg_write  <= ex_mem.valid && ex_mem.ctrl.reg_write;
            mem_wb.rd         <= ex_mem.rd;
            mem_wb.alu_result <= ex_mem.alu_result;
            mem_wb.load_data  <= ddata_r;
            mem_wb.pc_plus4   <= ex_mem.pc + pc_t'(4);
        end
    end

    // writeback stage
    always_comb begin
        case (mem_wb.wb_sel)
            WB_MEM: begin
                wb_value = mem_wb.load_data;
            end
            WB_PC4: begin
                // JAL link, zero-extended
                wb_value = word_t'(mem_wb.pc_plus4);
            end
            default: begin
                wb_value = mem_wb.alu_result;
            end
        endcase
    end

endmodule

`default_nettype wire

/* tests/rv_core_sva.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_core_sva import rv_pkg::*; (
    input wire logic     CLK,
    input wire logic     RESET_N,
    input wire logic     mem_read,
    input wire logic     mem_write,
    input wire logic     take_branch,
    input wire logic     reg_write,
    input wire reg_idx_t rd
);

    int   fail_count = 0;
    logic strobe;
    logic rf_write;

    assign strobe   = mem_read || mem_write;
    // writes to x0 change nothing
    assign rf_write = reg_write && rd != 5'd0;

    // quiet in reset and for four edges after release
    reset_quiet: assert property (@(posedge CLK)
        (strobe || rf_write) |-> RESET_N && $past(RESET_N, 1) && $past(RESET_N, 2) &&
                                 $past(RESET_N, 3) && $past(RESET_N, 4))
        else begin
            fail_count++;
            $error("memory strobe or register write during reset or right after it");
        end

    strobe_exclusive: assert property (@(posedge CLK) disable iff (!RESET_N)
        !(mem_read && mem_write))
        else begin
            fail_count++;
            $error("mem_read and mem_write high together");
        end

    // three flushed slots follow a taken branch
    flush_quiet: assert property (@(posedge CLK) disable iff (!RESET_N)
        strobe |-> !$past(take_branch, 1) && !$past(take_branch, 2) && !$past(take_branch, 3))
        else begin
            fail_count++;
            $error("memory strobe within three cycles of a taken branch");
        end

endmodule

bind rv_core rv_core_sva sva0 (
    .CLK         (CLK),
    .RESET_N     (RESET_N),
    .mem_read    (mem_read),
    .mem_write   (mem_write),
    .take_branch (take_branch),
    .reg_write   (mem_wb.reg_write),
    .rd          (mem_wb.rd)
);

`default_nettype wire

/* tests/rv_core_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_core_tb import rv_pkg::*; ();

    localparam word_t SEED = 32'h66b09ada;

    // one expected store
    typedef struct packed {
        waddr_t addr;
        word_t  data;
    } store_t;

    logic   CLK;
    logic   RESET_N;
    waddr_t iaddr;
    word_t  idata;
    waddr_t daddr;
    word_t  ddata_r;
    word_t  ddata_w;
    logic   mem_read;
    logic   mem_write;

    word_t rom [0:255];
    word_t ram [0:255];
    // initial RAM contents for the expected values
    word_t image [0:255];

    store_t exp_q[$];
    string  name_q[$];
    store_t head;
    string  head_name;

    int    n_instr = 0;
    int    next_slot = 128;
    int    halt_idx = 0;
    int    timeout_limit = 100000;
    int    cycles = 0;
    int    errors = 0;
    int    checked = 0;
    word_t rng;
    word_t op_a;
    word_t op_b;
    word_t op_c;

    // single-cycle memories
    assign idata   = rom[iaddr];
    // load data only while mem_read is up
    assign ddata_r = mem_read ? ram[daddr] : '0;

    rv_core dut0 (
        .CLK       (CLK),
        .RESET_N   (RESET_N),
        .iaddr     (iaddr),
        .idata     (idata),
        .daddr     (daddr),
        .ddata_r   (ddata_r),
        .ddata_w   (ddata_w),
        .mem_read  (mem_read),
        .mem_write (mem_write)
    );

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    function automatic word_t xorshift(input word_t x);
        word_t y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // instruction formats
    function automatic word_t r_word(input int f7, input int rs2, input int rs1,
                                     input int f3, input int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
    endfunction

    function automatic word_t i_word(input int imm, input int rs1, input int f3,
                                     input int rd, input logic [6:0] opc);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc};
    endfunction

    function automatic word_t s_word(input int imm, input int rs2, input int rs1);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic word_t b_word(input int imm, input int rs2, input int rs1, input int f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic word_t u_word(input int imm20, input int rd, input logic [6:0] opc);
        return {imm20[19:0], rd[4:0], opc};
    endfunction

    function automatic word_t j_word(input int imm, input int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
    endfunction

    task automatic place(input word_t instr);
        rom[n_instr[7:0]] = instr;
        n_instr++;
    endtask

    // three nops cover the missing forwarding
    task automatic gap();
        for (int k = 0; k < 3; k++) begin
            place(i_word(0, 0, 0, 0, OPC_OP_IMM));
        end
    endtask

    // SW to the next free slot plus its scoreboard entry
    task automatic store_reg(input int rs, input word_t value, input string name);
        store_t entry;
        place(s_word(next_slot * 4, rs, 0));
        entry.addr = waddr_t'(next_slot);
        entry.data = value;
        exp_q.push_back(entry);
        name_q.push_back(name);
        next_slot++;
    endtask

    // wrong-path stores that must be flushed
    task automatic skipped_stores();
        for (int k = 0; k < 3; k++) begin
            place(s_word(1000, 1, 0));
        end
    endtask

    // result always lands in x3
    task automatic alu_case(input word_t instr, input word_t expected, input string name);
        place(instr);
        gap();
        store_reg(3, expected, name);
    endtask

    // target sits right after the three shadow slots
    task automatic branch_case(input int f3, input int rs1, input int rs2,
                               input logic taken, input string name);
        place(b_word(16, rs2, rs1, f3));
        if (taken) begin
            skipped_stores();
        end else begin
            for (int k = 0; k < 3; k++) begin
                store_reg(1, op_a, name);
            end
        end
    endtask

    task automatic assemble_program();
        word_t link;
        // start-up bubble keeps the first memory stage idle
        place(i_word(0, 0, 0, 0, OPC_OP_IMM));
        // operands x1, x2 from RAM words 1 and 2
        place(i_word(4, 0, 2, 1, OPC_LOAD));
        place(i_word(8, 0, 2, 2, OPC_LOAD));
        gap();
        // x7 mirrors x1 for the equal compares
        place(i_word(0, 1, 0, 7, OPC_OP_IMM));
        gap();
        alu_case(r_word(0, 2, 1, 0, 3), op_a + op_b, "add");
        alu_case(r_word(32, 2, 1, 0, 3), op_a - op_b, "sub");
        alu_case(r_word(0, 2, 1, 1, 3), op_a << op_b[4:0], "sll");
        alu_case(r_word(0, 2, 1, 2, 3), {31'b0, $signed(op_a) < $signed(op_b)}, "slt");
        alu_case(r_word(0, 2, 1, 3, 3), {31'b0, op_a < op_b}, "sltu");
        alu_case(r_word(0, 2, 1, 4, 3), op_a ^ op_b, "xor");
        alu_case(r_word(0, 2, 1, 5, 3), op_a >> op_b[4:0], "srl");
        alu_case(r_word(32, 2, 1, 5, 3), word_t'($signed(op_a) >>> op_b[4:0]), "sra");
        alu_case(r_word(0, 2, 1, 6, 3), op_a | op_b, "or");
        alu_case(r_word(0, 2, 1, 7, 3), op_a & op_b, "and");
        // immediates sign extended from bit 11
        alu_case(i_word(-1234, 1, 0, 3, OPC_OP_IMM), op_a + word_t'(-1234), "addi");
        alu_case(i_word(-5, 1, 2, 3, OPC_OP_IMM), {31'b0, $signed(op_a) < -32'sd5}, "slti");
        alu_case(i_word(-1, 1, 3, 3, OPC_OP_IMM), {31'b0, op_a < 32'hffffffff}, "sltiu");
        alu_case(i_word(-1, 1, 4, 3, OPC_OP_IMM), ~op_a, "xori");
        alu_case(i_word(858, 1, 6, 3, OPC_OP_IMM), op_a | 32'h35a, "ori");
        alu_case(i_word(-256, 1, 7, 3, OPC_OP_IMM), op_a & 32'hffffff00, "andi");
        alu_case(i_word(7, 1, 1, 3, OPC_OP_IMM), op_a << 7, "slli");
        alu_case(i_word(13, 1, 5, 3, OPC_OP_IMM), op_a >> 13, "srli");
        // bit 10 of the immediate selects the arithmetic shift
        alu_case(i_word(1033, 1, 5, 3, OPC_OP_IMM), word_t'($signed(op_a) >>> 9), "srai");
        alu_case(u_word('habcde, 3, OPC_LUI), 32'habcde000, "lui");
        alu_case(u_word('h12345, 3, OPC_AUIPC), 32'h12345000 + word_t'(n_instr * 4), "auipc");
        // load a RAM word and store it elsewhere
        place(i_word(20, 0, 2, 4, OPC_LOAD));
        gap();
        store_reg(4, op_c, "lw");
        // first slot holds the add result by now
        place(i_word(512, 0, 2, 6, OPC_LOAD));
        gap();
        store_reg(6, op_a + op_b, "lw after sw");
        branch_case(0, 1, 7, 1'b1, "beq taken");
        branch_case(0, 1, 2, op_a == op_b, "beq not taken");
        branch_case(1, 1, 2, op_a != op_b, "bne taken");
        branch_case(1, 1, 7, 1'b0, "bne not taken");
        // link is the address after the JAL
        link = word_t'(n_instr * 4 + 4);
        place(j_word(16, 9));
        skipped_stores();
        store_reg(9, link, "jal link");
        halt_idx = n_instr;
        place(j_word(0, 0));
    endtask

    task automatic report_counts();
        $display("stores checked %0d, testbench errors %0d, assertion failures %0d",
                 checked, errors, dut0.sva0.fail_count);
    endtask

    // RAM model written at the edge that ends the memory stage
    always @(posedge CLK) begin
        if (mem_write) begin
            ram[daddr] <= ddata_w;
        end
    end

    // scoreboard against every store strobe
    always @(posedge CLK) begin
        if (RESET_N && mem_write) begin
            assert (exp_q.size() > 0) else begin
                errors++;
                $display("store to word %0d with data %h where none was expected",
                         daddr, ddata_w);
            end
            if (exp_q.size() > 0) begin
                head = exp_q.pop_front();
                head_name = name_q.pop_front();
                checked++;
                assert (daddr == head.addr) else begin
                    errors++;
                    $display("Fail %s address expected %0d actual %0d",
                             head_name, head.addr, daddr);
                end
                assert (ddata_w == head.data) else begin
                    errors++;
                    $display("Fail %s expected %h actual %h", head_name, head.data, ddata_w);
                end
            end
        end
    end

    always @(posedge CLK) begin
        cycles <= cycles + 1;
        if (cycles >= timeout_limit) begin
            $display("timeout after %0d cycles with %0d stores still missing",
                     cycles, exp_q.size());
            report_counts();
            $display("Checks failed");
            $finish;
        end
    end

    initial begin
        RESET_N = 1'b0;
        rng = SEED;
        for (int i = 0; i < 256; i++) begin
            rng = xorshift(rng);
            image[i[7:0]] = rng ^ {24'h0, i[7:0]};
            ram[i[7:0]] <= rng ^ {24'h0, i[7:0]};
            // spare ROM words are addi x0 with the address as immediate
            rom[i[7:0]] = i_word(i, 0, 0, 0, OPC_OP_IMM);
        end
        op_a = image[1];
        op_b = image[2];
        op_c = image[5];
        assemble_program();
        timeout_limit = 4 * n_instr + 50;
        repeat (8) @(posedge CLK);
        RESET_N <= 1'b1;
        // done once all stores are seen and the halt loop refetches
        while (exp_q.size() != 0 || iaddr != halt_idx[7:0]) begin
            @(negedge CLK);
        end
        repeat (8) @(posedge CLK);
        report_counts();
        if (errors == 0 && dut0.sva0.fail_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+hdl
hdl/rv_pkg.sv
hdl/rv_decoder.sv
hdl/rv_regfile.sv
hdl/rv_alu.sv
hdl/rv_core.sv
tests/rv_core_sva.sv
tests/rv_core_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the rv_core testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --assert -f verilog.f --top-module rv_core_tb -o rv_core_sim
output=$(./obj_dir/rv_core_sim +verilator+error+limit+100 || true)
echo "$output"
if echo "$output" | grep -q "^All checks passed$"; then
    exit 0
else
    exit 1
fi
